/* axi4_mem_sim.f */
verilog/axi4_mem_pkg.sv
verilog/axi4_busy_gate.sv
verilog/axi4_mem_ram.sv
verilog/axi4_mem_write.sv
verilog/axi4_mem_read.sv
verilog/axi4_mem_top.sv
tests/axi4_mem_clk_gen.sv
tests/axi4_mem_sva.sv
tests/axi4_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the axi4 memory testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=axi4_mem_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f axi4_mem_sim.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0

/* tests/axi4_mem_tb.sv */
`default_nettype none

module axi4_mem_tb
  import axi4_mem_pkg::*;
();

  localparam int   MEM_ADDR_WIDTH = 8;
  localparam int   MEM_WORDS      = 2 ** MEM_ADDR_WIDTH;
  localparam int   TIMEOUT        = 2000;
  localparam logic WR             = 1'b1;
  localparam logic RD             = 1'b0;
  localparam logic RND            = 1'b1;
  localparam logic FULL           = 1'b0;

  typedef struct packed {
    logic   is_write;
    logic   rand_strb;
    id_t    id;
    addr_t  addr;
    len_t   len;
    burst_e burst;
    data_t  seed;
    resp_e  resp;
  } row_t;

  logic   s_axi4_mem_aclk;
  logic   rst_i;
  id_t    awid_i;
  id_t    arid_i;
  id_t    bid_o;
  id_t    rid_o;
  addr_t  awaddr_i;
  addr_t  araddr_i;
  len_t   awlen_i;
  len_t   arlen_i;
  burst_e awburst_i;
  burst_e arburst_i;
  data_t  wdata_i;
  data_t  rdata_o;
  strb_t  wstrb_i;
  resp_e  bresp_o;
  resp_e  rresp_o;
  logic   awvalid_i;
  logic   awready_o;
  logic   wlast_i;
  logic   wvalid_i;
  logic   wready_o;
  logic   bvalid_o;
  logic   bready_i;
  logic   arvalid_i;
  logic   arready_o;
  logic   rlast_o;
  logic   rvalid_o;
  logic   rready_i;

  row_t  rows[$];
  string row_names[$];
  data_t ref_mem [MEM_WORDS];
  int    checks;
  int    mismatches;
  int    timeouts;
  int    sva_fails;

  axi4_mem_clk_gen #(
    .PERIOD       (20),
    .RESET_CYCLES (2)
  ) u_clk_gen (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .rst_o           (rst_i)
  );

  axi4_mem_top #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .AW_BUSY_RATE   (50),
    .W_BUSY_RATE    (50)
  ) UUT (.*);

  bind axi4_mem_top axi4_mem_sva u_sva (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .rst_i           (rst_i),
    .aw_valid_i      (awvalid_i),
    .aw_ready_i      (awready_o),
    .aw_payload_i    ({awid_i, awaddr_i, awlen_i, awburst_i}),
    .w_valid_i       (wvalid_i),
    .w_ready_i       (wready_o),
    .w_payload_i     ({wdata_i, wstrb_i, wlast_i}),
    .b_valid_i       (bvalid_o),
    .b_ready_i       (bready_i),
    .b_payload_i     ({bid_o, bresp_o}),
    .r_valid_i       (rvalid_o),
    .r_ready_i       (rready_i),
    .r_payload_i     ({rid_o, rdata_o, rresp_o, rlast_o})
  );

  // ==========================================================================
  // expected values
  // ==========================================================================
  function automatic word_addr_t beat_word(input addr_t addr, input burst_e burst,
                                           input int beat);
    word_addr_t word;
    word = addr[ADDR_WIDTH-1:2];
    if (burst == BURST_INCR) begin
      word = word + word_addr_t'(beat);
    end
    return word;
  endfunction

  function automatic logic beat_in_range(input word_addr_t word, input burst_e burst);
    return (int'(word) < MEM_WORDS) && (burst != BURST_WRAP);
  endfunction

  // high about three cycles in four
  function automatic logic pick_ready();
    return $urandom_range(3, 0) != 0;
  endfunction

  function automatic void add_row(input string name, input logic is_write,
                                  input logic rand_strb, input id_t id, input addr_t addr,
                                  input len_t len, input burst_e burst, input data_t seed,
                                  input resp_e resp);
    row_t r;
    r.is_write  = is_write;
    r.rand_strb = rand_strb;
    r.id        = id;
    r.addr      = addr;
    r.len       = len;
    r.burst     = burst;
    r.seed      = seed;
    r.resp      = resp;
    rows.push_back(r);
    row_names.push_back(name);
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input resp_e exp, input resp_e act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("[FAIL] %s: expected %s, actual %s (%b)", name, exp.name(), act.name(), act);
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("[FAIL] %s: expected id %0h, actual id %0h", name, exp, act);
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("[FAIL] %s: expected rlast %b, actual rlast %b", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
  endtask

  // ==========================================================================
  // channel tasks enter and leave on a falling edge
  // ==========================================================================
  task automatic send_aw(input row_t r);
    int cycles;
    if (timeouts != 0) return;
    awid_i    = r.id;
    awaddr_i  = r.addr;
    awlen_i   = r.len;
    awburst_i = r.burst;
    awvalid_i = 1'b1;
    cycles    = 0;
    while (!awready_o && cycles < TIMEOUT) begin
      @(negedge s_axi4_mem_aclk);
      cycles++;
    end
    if (!awready_o) report_timeout("write address handshake");
    @(negedge s_axi4_mem_aclk);
    awvalid_i = 1'b0;
  endtask

  task automatic send_w_beat(input data_t data, input strb_t strb, input logic last);
    int cycles;
    if (timeouts != 0) return;
    wdata_i  = data;
    wstrb_i  = strb;
    wlast_i  = last;
    wvalid_i = 1'b1;
    cycles   = 0;
    while (!wready_o && cycles < TIMEOUT) begin
      @(negedge s_axi4_mem_aclk);
      cycles++;
    end
    if (!wready_o) report_timeout("write data handshake");
    @(negedge s_axi4_mem_aclk);
    wvalid_i = 1'b0;
  endtask

  task automatic wait_b(output id_t id, output resp_e resp);
    int   cycles;
    logic got;
    id     = '0;
    resp   = RESP_OKAY;
    got    = 1'b0;
    cycles = 0;
    if (timeouts != 0) return;
    while (!got && cycles < TIMEOUT) begin
      bready_i = pick_ready();
      if (bvalid_o && bready_i) begin
        got  = 1'b1;
        id   = bid_o;
        resp = bresp_o;
      end else begin
        @(negedge s_axi4_mem_aclk);
        cycles++;
      end
    end
    if (!got) report_timeout("write response");
    @(negedge s_axi4_mem_aclk);
    bready_i = 1'b0;
  endtask

  task automatic send_ar(input row_t r);
    int cycles;
    if (timeouts != 0) return;
    arid_i    = r.id;
    araddr_i  = r.addr;
    arlen_i   = r.len;
    arburst_i = r.burst;
    arvalid_i = 1'b1;
    cycles    = 0;
    while (!arready_o && cycles < TIMEOUT) begin
      @(negedge s_axi4_mem_aclk);
      cycles++;
    end
    if (!arready_o) report_timeout("read address handshake");
    @(negedge s_axi4_mem_aclk);
    arvalid_i = 1'b0;
  endtask

  task automatic recv_r_beat(output data_t data, output resp_e resp, output id_t id,
                             output logic last);
    int   cycles;
    logic got;
    data   = '0;
    resp   = RESP_OKAY;
    id     = '0;
    last   = 1'b0;
    got    = 1'b0;
    cycles = 0;
    if (timeouts != 0) return;
    while (!got && cycles < TIMEOUT) begin
      rready_i = pick_ready();
      if (rvalid_o && rready_i) begin
        got  = 1'b1;
        data = rdata_o;
        resp = rresp_o;
        id   = rid_o;
        last = rlast_o;
      end else begin
        @(negedge s_axi4_mem_aclk);
        cycles++;
      end
    end
    if (!got) report_timeout("read data beat");
    @(negedge s_axi4_mem_aclk);
    rready_i = 1'b0;
  endtask

  // ==========================================================================
  // one table row
  // ==========================================================================
  task automatic run_write(input int idx);
    row_t       r;
    data_t      data;
    strb_t      strb;
    word_addr_t word;
    id_t        id;
    resp_e      resp;
    r = rows[idx];
    send_aw(r);
    for (int k = 0; k <= int'(r.len); k++) begin
      data = r.seed + data_t'(k);
      strb = r.rand_strb ? strb_t'($urandom_range(15, 0)) : '1;
      send_w_beat(data, strb, k == int'(r.len));
      word = beat_word(r.addr, r.burst, k);
      // dropped beats leave the reference copy alone
      if (beat_in_range(word, r.burst)) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (strb[b]) begin
            ref_mem[word[MEM_ADDR_WIDTH-1:0]][b*8 +: 8] = data[b*8 +: 8];
          end
        end
      end
    end
    wait_b(id, resp);
    if (timeouts == 0) begin
      check_id({row_names[idx], " bid"}, r.id, id);
      check_resp({row_names[idx], " bresp"}, r.resp, resp);
    end
  endtask

  task automatic run_read(input int idx);
    row_t       r;
    data_t      data;
    data_t      exp;
    resp_e      resp;
    id_t        id;
    logic       last;
    word_addr_t word;
    string      tag;
    r = rows[idx];
    send_ar(r);
    for (int k = 0; k <= int'(r.len); k++) begin
      recv_r_beat(data, resp, id, last);
      if (timeouts == 0) begin
        word = beat_word(r.addr, r.burst, k);
        exp  = beat_in_range(word, r.burst) ? ref_mem[word[MEM_ADDR_WIDTH-1:0]] : '0;
        tag  = $sformatf("%s beat %0d", row_names[idx], k);
        check_data(tag, exp, data);
        check_resp(tag, r.resp, resp);
        check_id(tag, r.id, id);
        check_last(tag, k == int'(r.len), last);
      end
    end
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    int cycles;
    void'($urandom(91495));
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    awid_i     = '0;
    awaddr_i   = '0;
    awlen_i    = '0;
    awburst_i  = BURST_INCR;
    awvalid_i  = 1'b0;
    wdata_i    = '0;
    wstrb_i    = '0;
    wlast_i    = 1'b0;
    wvalid_i   = 1'b0;
    bready_i   = 1'b0;
    arid_i     = '0;
    araddr_i   = '0;
    arlen_i    = '0;
    arburst_i  = BURST_INCR;
    arvalid_i  = 1'b0;
    rready_i   = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end

    // first row fills the whole array with values that follow the word address
    add_row("init_fill", WR, FULL, 4'h0, 16'h0000, 8'd255, BURST_INCR, 32'h3C00_0000, RESP_OKAY);
    add_row("incr_write", WR, FULL, 4'h3, 16'h0040, 8'd7, BURST_INCR, 32'h1111_0000, RESP_OKAY);
    add_row("incr_read", RD, FULL, 4'h3, 16'h0040, 8'd7, BURST_INCR, '0, RESP_OKAY);
    add_row("strobe_write", WR, RND, 4'h5, 16'h0100, 8'd3, BURST_INCR, 32'hA5A5_0000, RESP_OKAY);
    add_row("strobe_read", RD, FULL, 4'h5, 16'h0100, 8'd3, BURST_INCR, '0, RESP_OKAY);
    add_row("fixed_write", WR, FULL, 4'h6, 16'h0200, 8'd4, BURST_FIXED, 32'hF1F0_0000, RESP_OKAY);
    add_row("fixed_read", RD, FULL, 4'h6, 16'h0200, 8'd2, BURST_FIXED, '0, RESP_OKAY);
    add_row("oor_write", WR, FULL, 4'h9, 16'h0400, 8'd3, BURST_INCR, 32'hDEAD_0000, RESP_SLVERR);
    add_row("oor_read", RD, FULL, 4'h9, 16'h0400, 8'd3, BURST_INCR, '0, RESP_SLVERR);
    add_row("wrap_write", WR, FULL, 4'hA, 16'h0080, 8'd3, BURST_WRAP, 32'hBAD0_0000, RESP_SLVERR);
    add_row("wrap_read", RD, FULL, 4'hA, 16'h0080, 8'd3, BURST_WRAP, '0, RESP_SLVERR);
    add_row("post_wrap_read", RD, FULL, 4'hB, 16'h0080, 8'd3, BURST_INCR, '0, RESP_OKAY);
    add_row("edge_write", WR, FULL, 4'hC, 16'h03F8, 8'd3, BURST_INCR, 32'hE0E0_0000, RESP_SLVERR);
    add_row("edge_read", RD, FULL, 4'hC, 16'h03F8, 8'd1, BURST_INCR, '0, RESP_OKAY);
    add_row("low_read", RD, FULL, 4'hD, 16'h0000, 8'd1, BURST_INCR, '0, RESP_OKAY);
    add_row("long_write", WR, RND, 4'hF, 16'h0300, 8'd15, BURST_INCR, 32'h7700_0000, RESP_OKAY);
    add_row("long_read", RD, FULL, 4'hF, 16'h0300, 8'd15, BURST_INCR, '0, RESP_OKAY);

    cycles = 0;
    while (rst_i !== 1'b0 && cycles < TIMEOUT) begin
      @(posedge s_axi4_mem_aclk);
      cycles++;
    end
    if (rst_i !== 1'b0) report_timeout("reset release");
    @(negedge s_axi4_mem_aclk);

    for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
      if (rows[i].is_write) begin
        run_write(i);
      end else begin
        run_read(i);
      end
    end

    sva_fails = UUT.u_sva.fail_cnt;
    $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             checks, mismatches, timeouts, sva_fails);
    if (mismatches == 0 && timeouts == 0 && sva_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/axi4_mem_sva.sv */
`default_nettype none

module axi4_mem_sva
  import axi4_mem_pkg::*;
(
  input logic                             s_axi4_mem_aclk,
  input logic                             rst_i,
  input logic                             aw_valid_i,
  input logic                             aw_ready_i,
  input logic [ID_WIDTH+ADDR_WIDTH+9:0]   aw_payload_i,
  input logic                             w_valid_i,
  input logic                             w_ready_i,
  input logic [DATA_WIDTH+STRB_WIDTH:0]   w_payload_i,
  input logic                             b_valid_i,
  input logic                             b_ready_i,
  input logic [ID_WIDTH+1:0]              b_payload_i,
  input logic                             r_valid_i,
  input logic                             r_ready_i,
  input logic [ID_WIDTH+DATA_WIDTH+2:0]   r_payload_i
);

  int fail_cnt = 0;

  // ==========================================================================
  // valid and payload hold until ready
  // ==========================================================================
  aw_hold: assert property (@(posedge s_axi4_mem_aclk) disable iff (rst_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_payload_i))
    else begin
      fail_cnt++;
      $error("AW valid or payload changed before ready");
    end

  w_hold: assert property (@(posedge s_axi4_mem_aclk) disable iff (rst_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_payload_i))
    else begin
      fail_cnt++;
      $error("W valid or payload changed before ready");
    end

  b_hold: assert property (@(posedge s_axi4_mem_aclk) disable iff (rst_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_payload_i))
    else begin
      fail_cnt++;
      $error("B valid or payload changed before ready");
    end

  r_hold: assert property (@(posedge s_axi4_mem_aclk) disable iff (rst_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_payload_i))
    else begin
      fail_cnt++;
      $error("R valid or payload changed before ready");
    end

  // response channels quiet straight out of reset
  reset_quiet: assert property (@(posedge s_axi4_mem_aclk)
    rst_i |=> !b_valid_i && !r_valid_i)
    else begin
      fail_cnt++;
      $error("bvalid or rvalid high after reset");
    end

endmodule

`default_nettype wire

/* tests/axi4_mem_clk_gen.sv */
`default_nettype none

module axi4_mem_clk_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic s_axi4_mem_aclk,
  output logic rst_o
);

  initial begin
    s_axi4_mem_aclk = 1'b0;
    forever #(PERIOD / 2) s_axi4_mem_aclk = ~s_axi4_mem_aclk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge s_axi4_mem_aclk);
    @(negedge s_axi4_mem_aclk);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* verilog/axi4_mem_top.sv */
`default_nettype none

module axi4_mem_top
  import axi4_mem_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8,
  parameter int AW_BUSY_RATE   = 50,
  parameter int W_BUSY_RATE    = 50
) (
  input  logic   s_axi4_mem_aclk,
  input  logic   rst_i,
  input  id_t    awid_i,
  input  addr_t  awaddr_i,
  input  len_t   awlen_i,
  input  burst_e awburst_i,
  input  logic   awvalid_i,
  output logic   awready_o,
  input  data_t  wdata_i,
  input  strb_t  wstrb_i,
  input  logic   wlast_i,
  input  logic   wvalid_i,
  output logic   wready_o,
  output id_t    bid_o,
  output resp_e  bresp_o,
  output logic   bvalid_o,
  input  logic   bready_i,
  input  id_t    arid_i,
  input  addr_t  araddr_i,
  input  len_t   arlen_i,
  input  burst_e arburst_i,
  input  logic   arvalid_i,
  output logic   arready_o,
  output id_t    rid_o,
  output data_t  rdata_o,
  output resp_e  rresp_o,
  output logic   rlast_o,
  output logic   rvalid_o,
  input  logic   rready_i
);

  logic                      aw_valid_g;
  logic                      aw_ready_e;
  logic                      w_valid_g;
  logic                      w_ready_e;
  logic                      ram_we;
  logic [MEM_ADDR_WIDTH-1:0] ram_waddr;
  data_t                     ram_wdata;
  strb_t                     ram_wstrb;
  logic                      ram_re;
  logic [MEM_ADDR_WIDTH-1:0] ram_raddr;
  data_t                     ram_rdata;

  // ==========================================================================
  // busy gates on AW and W
  // ==========================================================================
  axi4_busy_gate #(
    .BUSY_RATE (AW_BUSY_RATE),
    .LFSR_SEED (16'hACE1)
  ) gate_aw (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .rst_i           (rst_i),
    .valid_i         (awvalid_i),
    .ready_i         (aw_ready_e),
    .valid_o         (aw_valid_g),
    .ready_o         (awready_o)
  );

  // different seed keeps the two gates out of step
  axi4_busy_gate #(
    .BUSY_RATE (W_BUSY_RATE),
    .LFSR_SEED (16'h1D2B)
  ) gate_w (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .rst_i           (rst_i),
    .valid_i         (wvalid_i),
    .ready_i         (w_ready_e),
    .valid_o         (w_valid_g),
    .ready_o         (wready_o)
  );

  // ==========================================================================
  // burst engines and array
  // ==========================================================================
  axi4_mem_write #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_write (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .rst_i           (rst_i),
    .awid_i          (awid_i),
    .awaddr_i        (awaddr_i),
    .awlen_i         (awlen_i),
    .awburst_i       (awburst_i),
    .awvalid_i       (aw_valid_g),
    .awready_o       (aw_ready_e),
    .wdata_i         (wdata_i),
    .wstrb_i         (wstrb_i),
    .wlast_i         (wlast_i),
    .wvalid_i        (w_valid_g),
    .wready_o        (w_ready_e),
    .bid_o           (bid_o),
    .bresp_o         (bresp_o),
    .bvalid_o        (bvalid_o),
    .bready_i        (bready_i),
    .ram_we_o        (ram_we),
    .ram_waddr_o     (ram_waddr),
    .ram_wdata_o     (ram_wdata),
    .ram_wstrb_o     (ram_wstrb)
  );

  axi4_mem_read #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_read (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .rst_i           (rst_i),
    .arid_i          (arid_i),
    .araddr_i        (araddr_i),
    .arlen_i         (arlen_i),
    .arburst_i       (arburst_i),
    .arvalid_i       (arvalid_i),
    .arready_o       (arready_o),
    .rid_o           (rid_o),
    .rdata_o         (rdata_o),
    .rresp_o         (rresp_o),
    .rlast_o         (rlast_o),
    .rvalid_o        (rvalid_o),
    .rready_i        (rready_i),
    .ram_re_o        (ram_re),
    .ram_raddr_o     (ram_raddr),
    .ram_rdata_i     (ram_rdata)
  );

  axi4_mem_ram #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_ram (
    .s_axi4_mem_aclk (s_axi4_mem_aclk),
    .we_i            (ram_we),
    .waddr_i         (ram_waddr),
    .wdata_i         (ram_wdata),
    .wstrb_i         (ram_wstrb),
    .re_i            (ram_re),
    .raddr_i         (ram_raddr),
    .rdata_o         (ram_rdata)
  );

endmodule

`default_nettype wire

/* verilog/axi4_mem_read.sv */
`default_nettype none

module axi4_mem_read
  import axi4_mem_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                      s_axi4_mem_aclk,
  input  logic                      rst_i,
  input  id_t                       arid_i,
  input  addr_t                     araddr_i,
  input  len_t                      arlen_i,
  input  burst_e                    arburst_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  output id_t                       rid_o,
  output data_t                     rdata_o,
  output resp_e                     rresp_o,
  output logic                      rlast_o,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic                      ram_re_o,
  output logic [MEM_ADDR_WIDTH-1:0] ram_raddr_o,
  input  data_t                     ram_rdata_i
);

  rd_state_e  state_q;
  id_t        id_q;
  word_addr_t addr_q;
  len_t       len_q;
  len_t       beat_q;
  burst_e     burst_q;
  logic       beat_ok;
  logic       ar_fire;
  logic       r_fire;

  assign beat_ok = ((addr_q >> MEM_ADDR_WIDTH) == '0) && (burst_q != BURST_WRAP);
  assign ar_fire = arvalid_i && arready_o;
  assign r_fire  = rvalid_o && rready_i;

  // ==========================================================================
  // burst FSM
  // ==========================================================================
  always_ff @(posedge s_axi4_mem_aclk) begin
    if (rst_i) begin
      state_q   <= RD_IDLE;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          arready_o <= 1'b1;
          if (ar_fire) begin
            state_q   <= RD_FETCH;
            arready_o <= 1'b0;
          end
        end
        RD_FETCH: begin
          // ram output is ready next cycle
          state_q  <= RD_DATA;
          rvalid_o <= 1'b1;
        end
        default: begin
          if (r_fire) begin
            rvalid_o <= 1'b0;
            if (rlast_o) begin
              state_q   <= RD_IDLE;
              arready_o <= 1'b1;
            end else begin
              state_q <= RD_FETCH;
            end
          end
        end
      endcase
    end
  end

  // address steps once the beat is taken
  always_ff @(posedge s_axi4_mem_aclk) begin
    if (ar_fire) begin
      id_q    <= arid_i;
      addr_q  <= araddr_i[ADDR_WIDTH-1:BYTE_BITS];
      len_q   <= arlen_i;
      burst_q <= arburst_i;
      beat_q  <= '0;
    end else if (r_fire) begin
      beat_q <= beat_q + 8'd1;
      if (burst_q == BURST_INCR) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign ram_re_o    = (state_q == RD_FETCH) && beat_ok;
  assign ram_raddr_o = addr_q[MEM_ADDR_WIDTH-1:0];

  // ram output holds while rready is low
  assign rid_o   = id_q;
  assign rdata_o = beat_ok ? ram_rdata_i : '0;
  assign rresp_o = beat_ok ? RESP_OKAY : RESP_SLVERR;
  assign rlast_o = (beat_q == len_q);

endmodule

`default_nettype wire

/* verilog/axi4_mem_write.sv */
`default_nettype none

module axi4_mem_write
  import axi4_mem_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                      s_axi4_mem_aclk,
  input  logic                      rst_i,
  input  id_t                       awid_i,
  input  addr_t                     awaddr_i,
  input  len_t                      awlen_i,
  input  burst_e                    awburst_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  data_t                     wdata_i,
  input  strb_t                     wstrb_i,
  input  logic                      wlast_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  output id_t                       bid_o,
  output resp_e                     bresp_o,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  output logic                      ram_we_o,
  output logic [MEM_ADDR_WIDTH-1:0] ram_waddr_o,
  output data_t                     ram_wdata_o,
  output strb_t                     ram_wstrb_o
);

  wr_state_e  state_q;
  logic       err_q;
  id_t        id_q;
  word_addr_t addr_q;
  len_t       len_q;
  len_t       beat_q;
  burst_e     burst_q;
  logic       beat_ok;
  logic       w_fire;

  assign beat_ok = ((addr_q >> MEM_ADDR_WIDTH) == '0) && (burst_q != BURST_WRAP);
  assign w_fire  = wvalid_i && wready_o;

  // ==========================================================================
  // burst FSM
  // ==========================================================================
  always_ff @(posedge s_axi4_mem_aclk) begin
    if (rst_i) begin
      state_q   <= WR_IDLE;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          awready_o <= 1'b1;
          if (awvalid_i && awready_o) begin
            state_q   <= WR_DATA;
            awready_o <= 1'b0;
            wready_o  <= 1'b1;
            err_q     <= (awburst_i == BURST_WRAP);
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            // a wlast off the awlen count also counts as an error
            if (!beat_ok || (wlast_i != (beat_q == len_q))) begin
              err_q <= 1'b1;
            end
            if (wlast_i) begin
              state_q  <= WR_RESP;
              wready_o <= 1'b0;
              bvalid_o <= 1'b1;
            end
          end
        end
        default: begin
          if (bready_i) begin
            state_q   <= WR_IDLE;
            bvalid_o  <= 1'b0;
            awready_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // burst payload
  always_ff @(posedge s_axi4_mem_aclk) begin
    if (awvalid_i && awready_o) begin
      id_q    <= awid_i;
      addr_q  <= awaddr_i[ADDR_WIDTH-1:BYTE_BITS];
      len_q   <= awlen_i;
      burst_q <= awburst_i;
      beat_q  <= '0;
    end else if (w_fire) begin
      beat_q <= beat_q + 8'd1;
      if (burst_q == BURST_INCR) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign bid_o   = id_q;
  assign bresp_o = err_q ? RESP_SLVERR : RESP_OKAY;

  // out of range beats never reach the array
  assign ram_we_o    = w_fire && beat_ok;
  assign ram_waddr_o = addr_q[MEM_ADDR_WIDTH-1:0];
  assign ram_wdata_o = wdata_i;
  assign ram_wstrb_o = wstrb_i;

endmodule

`default_nettype wire

/* verilog/axi4_mem_ram.sv */
`default_nettype none

module axi4_mem_ram
  import axi4_mem_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                      s_axi4_mem_aclk,
  input  logic                      we_i,
  input  logic [MEM_ADDR_WIDTH-1:0] waddr_i,
  input  data_t                     wdata_i,
  input  strb_t                     wstrb_i,
  input  logic                      re_i,
  input  logic [MEM_ADDR_WIDTH-1:0] raddr_i,
  output data_t                     rdata_o
);

  data_t mem [2**MEM_ADDR_WIDTH];

  always_ff @(posedge s_axi4_mem_aclk) begin
    if (we_i) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wstrb_i[b]) begin
          mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

/* verilog/axi4_busy_gate.sv */
`default_nettype none

module axi4_busy_gate #(
  parameter int              BUSY_RATE = 50,
  parameter logic [15:0]     LFSR_SEED = 16'hACE1
) (
  input  logic s_axi4_mem_aclk,
  input  logic rst_i,
  input  logic valid_i,
  input  logic ready_i,
  output logic valid_o,
  output logic ready_o
);

  // percent scaled onto the 8-bit lfsr slice
  localparam int BUSY_THRESH = BUSY_RATE * 256 / 100;

  logic [15:0] lfsr_q;
  logic        lfsr_fb;
  logic        busy_d;
  logic        busy_q;

  // taps 16,14,13,11
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  assign busy_d  = int'(lfsr_q[7:0]) < BUSY_THRESH;

  always_ff @(posedge s_axi4_mem_aclk) begin
    if (rst_i) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
    end
  end

  // only switch while idle or on the completing beat,
  // so an offered valid stays up until it is taken
  always_ff @(posedge s_axi4_mem_aclk) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (!valid_o || ready_i) begin
      busy_q <= busy_d;
    end
  end

  assign valid_o = valid_i && !busy_q;
  assign ready_o = ready_i && !busy_q;

endmodule

`default_nettype wire

/* verilog/axi4_mem_pkg.sv */
`default_nettype none

package axi4_mem_pkg;

  // ==========================================================================
  // bus widths
  // ==========================================================================
  localparam int ID_WIDTH   = 4;
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int BYTE_BITS  = $clog2(STRB_WIDTH);

  typedef logic [ID_WIDTH-1:0]             id_t;
  typedef logic [ADDR_WIDTH-1:0]           addr_t;
  typedef logic [DATA_WIDTH-1:0]           data_t;
  typedef logic [STRB_WIDTH-1:0]           strb_t;
  typedef logic [7:0]                      len_t;
  // byte address with the byte offset dropped
  typedef logic [ADDR_WIDTH-BYTE_BITS-1:0] word_addr_t;

  // ==========================================================================
  // encodings
  // ==========================================================================
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_DATA} rd_state_e;

endpackage

`default_nettype wire
